/* flist.f */
hps_pkg.sv
hps_word_framer.sv
hps_cmd_decoder.sv
hps_input_regs.sv
hps_file_loader.sv
hps_link.sv
tb_hps_link.sv

/* tb_hps_link.sv */
/*
 * Testbench for the host link. Sends user-I/O and file-I/O frames on
 * the host bus and checks the core ports against a reference model.
 */

`timescale 1ns/1ps

module tb_hps_link import hps_pkg::*; ();

	localparam logic [31:0] SEED = 32'habe0_d971;
	localparam int N_JOY_FRAMES  = 20;
	localparam int N_REQ_ROUNDS  = 2;
	localparam int N_DL_WORDS    = 16;
	// strobes, frame ends and status pulses over all tests, rounded up
	localparam int TOTAL_WORDS   = N_JOY_FRAMES*5 + 16 + N_REQ_ROUNDS*11 + 24 + N_DL_WORDS;
	localparam int TIMEOUT_CYC   = TOTAL_WORDS*10 + 200;

	// command codes as the host sends them
	localparam logic [HOST_W-1:0] C_CFG     = 16'h0001;
	localparam logic [HOST_W-1:0] C_JOY0    = 16'h0002;
	localparam logic [HOST_W-1:0] C_JOY1    = 16'h0003;
	localparam logic [HOST_W-1:0] C_JOY2    = 16'h0010;
	localparam logic [HOST_W-1:0] C_JOY3    = 16'h0011;
	localparam logic [HOST_W-1:0] C_STATUS  = 16'h001E;
	localparam logic [HOST_W-1:0] C_STREQ   = 16'h0029;
	localparam logic [HOST_W-1:0] C_UNKNOWN = 16'h0077;
	localparam logic [HOST_W-1:0] C_FTX     = 16'h0053;
	localparam logic [HOST_W-1:0] C_FDAT    = 16'h0054;
	localparam logic [HOST_W-1:0] C_FIDX    = 16'h0055;
	localparam logic [HOST_W-1:0] C_FINFO   = 16'h0056;

	typedef struct packed {
		logic [JOY_N-1:0][JOY_W-1:0] joy;
		logic [STATUS_W-1:0]         status;
		logic [HOST_W-1:0]           cfg;
		logic [HOST_W-1:0]           dout;
	} io_model_t;

	typedef struct packed {
		logic                   dl;
		logic [HOST_W-1:0]      index;
		logic [2*HOST_W-1:0]    ext;
		logic [FILE_ADDR_W-1:0] addr;
		logic                   wr;
		logic [FILE_ADDR_W-1:0] wr_addr;
		logic [FILE_DATA_W-1:0] wr_data;
	} fio_model_t;

	logic                        clk_sys;
	logic                        rst;
	logic                        io_strobe;
	logic                        io_enable;
	logic                        fp_enable;
	logic [HOST_W-1:0]           io_din;
	logic [HOST_W-1:0]           io_dout;
	logic                        status_set;
	logic [STATUS_W-1:0]         status_in;
	logic [JOY_N-1:0][JOY_W-1:0] joystick;
	logic [STATUS_W-1:0]         status;
	logic [1:0]                  buttons;
	logic                        forced_scandoubler;
	logic                        direct_video;
	logic                        ioctl_download;
	logic [HOST_W-1:0]           ioctl_index;
	logic [2*HOST_W-1:0]         ioctl_file_ext;
	logic                        ioctl_wr;
	logic [FILE_ADDR_W-1:0]      ioctl_addr;
	logic [FILE_DATA_W-1:0]      ioctl_dout;

	io_model_t                          io_m;
	fio_model_t                         fio_m;
	logic [STFLG_W-1:0]                 exp_stflg;
	logic [STATUS_W-1:0]                exp_req;
	logic [FILE_ADDR_W+FILE_DATA_W-1:0] wr_q [$];
	bit                                 cur_fio;
	logic [HOST_W-1:0]                  cur_cmd;
	int                                 cur_idx;
	logic                               chk_req;
	logic [2:0]                         chk_pipe;
	int                                 err_cnt = 0;
	int                                 chk_cnt = 0;
	string                              test_name = "reset";

	hps_link i_dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	initial begin
		repeat (TIMEOUT_CYC) @(posedge clk_sys);
		$display("watchdog expired after %0d cycles, the run did not finish", TIMEOUT_CYC);
		$display("TEST FAIL");
		$finish;
	end

	///////////////////////////////////////////////////////////////////////
	// reference model

	function automatic io_model_t ref_io(input io_model_t m, input bit is_end,
		input logic [HOST_W-1:0] cmd, input int idx, input logic [HOST_W-1:0] data,
		input logic [STFLG_W-1:0] cnt, input logic [STATUS_W-1:0] req);
		io_model_t r;
		int        j;
		r      = m;
		r.dout = '0;
		j      = -1;
		if (is_end)
			return r;
		if (idx == 0) begin
			if (cmd == C_STREQ)
				r.dout = {8'h00, 4'hA, cnt};
			return r;
		end
		case (cmd)
			C_CFG:    r.cfg = data;
			C_JOY0:   j = 0;
			C_JOY1:   j = 1;
			C_JOY2:   j = 2;
			C_JOY3:   j = 3;
			C_STATUS: begin
				if (idx <= 4)
					r.status[(idx-1)*16 +: 16] = data;
			end
			C_STREQ: begin
				if (idx <= 4)
					r.dout = req[(idx-1)*16 +: 16];
			end
			default:  ;
		endcase
		// low half first, any later word lands in the high half
		if (j >= 0) begin
			if (idx == 1)
				r.joy[j][15:0] = data;
			else
				r.joy[j][31:16] = data;
		end
		return r;
	endfunction

	function automatic fio_model_t ref_fio(input fio_model_t m, input logic [HOST_W-1:0] cmd,
		input int idx, input logic [HOST_W-1:0] data);
		fio_model_t r;
		r    = m;
		r.wr = 1'b0;
		// the command word only opens the frame
		if (idx == 0)
			return r;
		case (cmd)
			C_FIDX:
				r.index = data;
			C_FINFO: begin
				if (idx == 1)
					r.ext[31:16] = data;
				else if (idx == 2)
					r.ext[15:0] = data;
			end
			C_FTX: begin
				if (idx == 1) begin
					r.dl = (data[7:0] != 8'h00);
					if (r.dl)
						r.addr = '0;
				end else if (idx == 2) begin
					r.addr[15:0] = data;
				end else if (idx == 3) begin
					r.addr[26:16] = data[10:0];
				end
			end
			// one byte per payload word while downloading
			C_FDAT: begin
				if (r.dl) begin
					r.wr      = 1'b1;
					r.wr_addr = r.addr;
					r.wr_data = data[7:0];
					r.addr    = r.addr + 1'b1;
				end
			end
			default: ;
		endcase
		return r;
	endfunction

	///////////////////////////////////////////////////////////////////////
	// host bus tasks

	task automatic frame_open(input bit fio);
		cur_fio = fio;
		cur_idx = 0;
		@(posedge clk_sys);
		io_strobe <= 1'b0;
		if (fio)
			fp_enable <= 1'b1;
		else
			io_enable <= 1'b1;
	endtask

	// unchecked words go out back to back
	task automatic send_word(input logic [HOST_W-1:0] data, input bit check);
		if (cur_idx == 0)
			cur_cmd = data;
		if (cur_fio) begin
			fio_m = ref_fio(fio_m, cur_cmd, cur_idx, data);
			if (fio_m.wr)
				wr_q.push_back({fio_m.wr_addr, fio_m.wr_data});
		end else begin
			io_m = ref_io(io_m, 1'b0, cur_cmd, cur_idx, data, exp_stflg, exp_req);
		end
		if (cur_idx < 7)
			cur_idx++;
		@(posedge clk_sys);
		io_strobe <= 1'b1;
		io_din    <= data;
		chk_req   <= check;
		if (check) begin
			@(posedge clk_sys);
			io_strobe <= 1'b0;
			chk_req   <= 1'b0;
			repeat (4) @(posedge clk_sys);
		end
	endtask

	task automatic frame_close(input bit check);
		if (!cur_fio)
			io_m = ref_io(io_m, 1'b1, cur_cmd, cur_idx, '0, exp_stflg, exp_req);
		@(posedge clk_sys);
		io_strobe <= 1'b0;
		io_enable <= 1'b0;
		fp_enable <= 1'b0;
		chk_req   <= check;
		@(posedge clk_sys);
		chk_req <= 1'b0;
		repeat (4) @(posedge clk_sys);
	endtask

	task automatic check_idle();
		@(posedge clk_sys);
		chk_req <= 1'b1;
		@(posedge clk_sys);
		chk_req <= 1'b0;
		repeat (4) @(posedge clk_sys);
	endtask

	task automatic pulse_status_set();
		logic [STATUS_W-1:0] v;
		v         = {$urandom, $urandom};
		exp_stflg = exp_stflg + 1'b1;
		exp_req   = v;
		@(posedge clk_sys);
		status_set <= 1'b1;
		status_in  <= v;
		@(posedge clk_sys);
		status_set <= 1'b0;
		repeat (2) @(posedge clk_sys);
	endtask

	///////////////////////////////////////////////////////////////////////
	// checking

	task automatic report_mismatch(input string what, input logic [63:0] exp,
		input logic [63:0] act);
		$display("Error %s, %s: expected %0h, actual %0h", test_name, what, exp, act);
		err_cnt++;
	endtask

	// three cycles after a checked strobe or enable fall
	always @(posedge clk_sys) begin
		if (rst)
			chk_pipe <= '0;
		else
			chk_pipe <= {chk_pipe[1:0], chk_req};
	end

	always @(negedge clk_sys) begin
		if (chk_pipe[2]) begin
			chk_cnt++;
			for (int j = 0; j < JOY_N; j++) begin
				if (joystick[j] !== io_m.joy[j])
					report_mismatch($sformatf("joystick%0d", j), io_m.joy[j], joystick[j]);
			end
			if (status !== io_m.status)
				report_mismatch("status", io_m.status, status);
			if (buttons !== io_m.cfg[1:0])
				report_mismatch("buttons", io_m.cfg[1:0], buttons);
			if (forced_scandoubler !== io_m.cfg[4])
				report_mismatch("forced_scandoubler", io_m.cfg[4], forced_scandoubler);
			if (direct_video !== io_m.cfg[10])
				report_mismatch("direct_video", io_m.cfg[10], direct_video);
			if (io_dout !== io_m.dout)
				report_mismatch("io_dout", io_m.dout, io_dout);
			if (ioctl_download !== fio_m.dl)
				report_mismatch("ioctl_download", fio_m.dl, ioctl_download);
			if (ioctl_index !== fio_m.index)
				report_mismatch("ioctl_index", fio_m.index, ioctl_index);
			if (ioctl_file_ext !== fio_m.ext)
				report_mismatch("ioctl_file_ext", fio_m.ext, ioctl_file_ext);
		end
	end

	always @(negedge clk_sys) begin : wr_monitor
		logic [FILE_ADDR_W+FILE_DATA_W-1:0] exp_wr;
		if (!rst && ioctl_wr !== 1'b0) begin
			if (wr_q.size() == 0) begin
				$display("%s: write pulse at address %0h with no data word pending",
					test_name, ioctl_addr);
				err_cnt++;
			end else begin
				exp_wr = wr_q.pop_front();
				if ({ioctl_addr, ioctl_dout} !== exp_wr)
					report_mismatch("ioctl_addr/ioctl_dout", exp_wr, {ioctl_addr, ioctl_dout});
			end
		end
	end

	///////////////////////////////////////////////////////////////////////
	// stimulus

	initial begin : stimulus
		logic [HOST_W-1:0]      cmds [5];
		logic [FILE_ADDR_W-1:0] start_addr;
		int                     n;
		rst        = 1'b1;
		io_strobe  = 1'b0;
		io_enable  = 1'b0;
		fp_enable  = 1'b0;
		io_din     = '0;
		status_set = 1'b0;
		status_in  = '0;
		chk_req    = 1'b0;
		io_m       = '0;
		fio_m      = '0;
		fio_m.index = 'x;
		fio_m.ext   = 'x;
		exp_stflg  = '0;
		exp_req    = 'x;
		cur_fio    = 1'b0;
		cur_cmd    = '0;
		cur_idx    = 0;
		cmds       = '{C_JOY0, C_JOY1, C_JOY2, C_JOY3, C_CFG};
		void'($urandom(SEED));
		repeat (10) @(posedge clk_sys);
		rst <= 1'b0;
		check_idle();

		test_name = "joystick_cfg";
		for (int f = 0; f < N_JOY_FRAMES; f++) begin
			frame_open(1'b0);
			send_word(cmds[$urandom_range(0, 4)], 1'b1);
			n = $urandom_range(1, 3);
			for (int k = 0; k < n; k++)
				send_word(HOST_W'($urandom), 1'b1);
			frame_close(1'b1);
		end

		test_name = "status_write";
		frame_open(1'b0);
		send_word(C_STATUS, 1'b1);
		for (int k = 0; k < 4; k++)
			send_word(HOST_W'($urandom), 1'b1);
		frame_close(1'b1);

		test_name = "unknown_cmd";
		frame_open(1'b0);
		send_word(C_UNKNOWN, 1'b1);
		for (int k = 0; k < 3; k++)
			send_word(HOST_W'($urandom), 1'b1);
		frame_close(1'b1);

		test_name = "status_request";
		for (int r = 0; r < N_REQ_ROUNDS; r++) begin
			n = $urandom_range(1, 4);
			for (int p = 0; p < n; p++)
				pulse_status_set();
			frame_open(1'b0);
			send_word(C_STREQ, 1'b1);
			for (int k = 0; k < 4; k++)
				send_word(HOST_W'($urandom), 1'b1);
			frame_close(1'b1);
		end

		test_name = "download";
		frame_open(1'b1);
		send_word(C_FIDX, 1'b1);
		send_word(HOST_W'($urandom), 1'b1);
		frame_close(1'b1);
		frame_open(1'b1);
		send_word(C_FINFO, 1'b1);
		send_word(HOST_W'($urandom), 1'b1);
		send_word(HOST_W'($urandom), 1'b1);
		frame_close(1'b1);
		start_addr = FILE_ADDR_W'($urandom);
		frame_open(1'b1);
		send_word(C_FTX, 1'b1);
		send_word(HOST_W'($urandom) | 16'h0001, 1'b1);
		send_word(start_addr[15:0], 1'b1);
		send_word(HOST_W'(start_addr[26:16]), 1'b1);
		frame_close(1'b1);
		frame_open(1'b1);
		send_word(C_FDAT, 1'b0);
		for (int k = 0; k < N_DL_WORDS; k++)
			send_word(HOST_W'($urandom), 1'b0);
		frame_close(1'b1);
		frame_open(1'b1);
		send_word(C_FTX, 1'b1);
		send_word(16'h0000, 1'b1);
		frame_close(1'b1);

		test_name = "data_idle";
		frame_open(1'b1);
		send_word(C_FDAT, 1'b1);
		for (int k = 0; k < 3; k++)
			send_word(HOST_W'($urandom), 1'b1);
		frame_close(1'b1);

		repeat (10) @(posedge clk_sys);
		if (wr_q.size() != 0) begin
			$display("%0d expected write pulses never appeared", wr_q.size());
			err_cnt++;
		end
		$display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

/* hps_link.sv */
/*
 * Host link top level. Host words pass framer, decoder, then the
 * user-I/O registers or the file loader.
 */

`timescale 1ns/1ps

module hps_link import hps_pkg::*; (
	input  logic                        clk_sys,
	input  logic                        rst,

	// host bus
	input  logic                        io_strobe,
	input  logic                        io_enable,
	input  logic                        fp_enable,
	input  logic [HOST_W-1:0]           io_din,
	output logic [HOST_W-1:0]           io_dout,

	// core side, user I/O
	input  logic                        status_set,
	input  logic [STATUS_W-1:0]         status_in,
	output logic [JOY_N-1:0][JOY_W-1:0] joystick,
	output logic [STATUS_W-1:0]         status,
	output logic [1:0]                  buttons,
	output logic                        forced_scandoubler,
	output logic                        direct_video,

	// core side, file download
	output logic                        ioctl_download,
	output logic [HOST_W-1:0]           ioctl_index,
	output logic [2*HOST_W-1:0]         ioctl_file_ext,
	output logic                        ioctl_wr,
	output logic [FILE_ADDR_W-1:0]      ioctl_addr,
	output logic [FILE_DATA_W-1:0]      ioctl_dout
);

	host_word_t word;
	io_op_t     io_op;
	fio_op_t    fio_op;

	hps_word_framer i_framer (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.io_strobe (io_strobe),
		.io_enable (io_enable),
		.fp_enable (fp_enable),
		.io_din    (io_din),
		.word      (word)
	);

	hps_cmd_decoder i_decoder (
		.clk_sys (clk_sys),
		.rst     (rst),
		.word    (word),
		.io_op   (io_op),
		.fio_op  (fio_op)
	);

	hps_input_regs i_input_regs (
		.clk_sys            (clk_sys),
		.rst                (rst),
		.io_op              (io_op),
		.status_set         (status_set),
		.status_in          (status_in),
		.joystick           (joystick),
		.status             (status),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.io_dout            (io_dout)
	);

	hps_file_loader i_file_loader (
		.clk_sys        (clk_sys),
		.rst            (rst),
		.fio_op         (fio_op),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_file_ext (ioctl_file_ext),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout)
	);

endmodule

/* hps_file_loader.sv */
/*
 * Stage 3 for file I/O. Tracks the download state and address and
 * sends one write pulse per data word to the core.
 */

`timescale 1ns/1ps

module hps_file_loader import hps_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   rst,
	input  fio_op_t                fio_op,
	output logic                   ioctl_download,
	output logic [HOST_W-1:0]      ioctl_index,
	output logic [2*HOST_W-1:0]    ioctl_file_ext,
	output logic                   ioctl_wr,
	output logic [FILE_ADDR_W-1:0] ioctl_addr,
	output logic [FILE_DATA_W-1:0] ioctl_dout
);

	logic [FILE_ADDR_W-1:0] addr;
	logic                   payload;
	logic                   tx_ctl;
	logic                   start;
	logic                   dat;

	// the command word only selects the operation
	assign payload = fio_op.valid && (fio_op.idx != '0);
	// first FILE_TX payload word carries start or stop
	assign tx_ctl = fio_op.valid && (fio_op.cmd == FIO_FILE_TX) && (fio_op.idx == IDX_W'(1));
	assign start  = fio_op.data[FILE_DATA_W-1:0] != '0;
	assign dat    = payload && (fio_op.cmd == FIO_FILE_TX_DAT) && ioctl_download;

	///////////////////////////////////////////////////////////////////////
	// download state and write strobe

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			ioctl_download <= 1'b0;
			ioctl_wr       <= 1'b0;
		end else begin
			ioctl_wr <= dat;
			if (tx_ctl)
				ioctl_download <= start;
		end
	end

	///////////////////////////////////////////////////////////////////////
	// index, extension and address

	always_ff @(posedge clk_sys) begin
		if (payload) begin
			case (fio_op.cmd)
				FIO_FILE_INDEX:
					ioctl_index <= fio_op.data;
				FIO_FILE_INFO: begin
					if (fio_op.idx == IDX_W'(1))
						ioctl_file_ext[HOST_W +: HOST_W] <= fio_op.data;
					else if (fio_op.idx == IDX_W'(2))
						ioctl_file_ext[0 +: HOST_W] <= fio_op.data;
				end
				FIO_FILE_TX: begin
					case (fio_op.idx)
						IDX_W'(1): begin
							if (start)
								addr <= '0;
							else if (ioctl_download)
								// at stop the address shows the file length
								ioctl_addr <= addr;
						end
						IDX_W'(2):
							addr[0 +: HOST_W] <= fio_op.data;
						IDX_W'(3):
							addr[FILE_ADDR_W-1:HOST_W] <= fio_op.data[FILE_ADDR_W-HOST_W-1:0];
						default:
							addr <= addr;
					endcase
				end
				FIO_FILE_TX_DAT: begin
					// data while idle is dropped
					if (ioctl_download) begin
						ioctl_addr <= addr;
						ioctl_dout <= fio_op.data[FILE_DATA_W-1:0];
						addr       <= addr + FILE_ADDR_W'(1);
					end
				end
				default:
					addr <= addr;
			endcase
		end
	end

	a_wr_in_dl: assert property (@(posedge clk_sys) disable iff (rst)
		ioctl_wr |-> ioctl_download)
		else $error("ioctl_wr outside a download");

endmodule

/* hps_input_regs.sv */
/*
 * Stage 3 for user I/O. Holds joysticks, config and status, captures
 * core status requests and forms the word read back by the host.
 */

`timescale 1ns/1ps

module hps_input_regs import hps_pkg::*; (
	input  logic                            clk_sys,
	input  logic                            rst,
	input  io_op_t                          io_op,
	input  logic                            status_set,
	input  logic [STATUS_W-1:0]             status_in,
	output logic [JOY_N-1:0][JOY_W-1:0]     joystick,
	output logic [STATUS_W-1:0]             status,
	output logic [1:0]                      buttons,
	output logic                            forced_scandoubler,
	output logic                            direct_video,
	output logic [HOST_W-1:0]               io_dout
);

	logic [HOST_W-1:0]     cfg;
	logic [STATUS_W-1:0]   status_req;
	logic [STFLG_W-1:0]    stflg;
	logic                  status_set_q;
	logic                  status_rise;
	logic [IDX_W-1:0]      idx_m1;
	logic [STAT_SEL_W-1:0] word_sel;
	logic                  word_hit;

	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[CFG_FSD_BIT];
	assign direct_video       = cfg[CFG_DV_BIT];

	// payload word k goes to status word k-1
	assign idx_m1   = io_op.idx - IDX_W'(1);
	assign word_sel = idx_m1[STAT_SEL_W-1:0];
	assign word_hit = (io_op.idx != '0) && (io_op.idx <= IDX_W'(STAT_WORDS));

	///////////////////////////////////////////////////////////////////////
	// core-requested status update

	assign status_rise = status_set & ~status_set_q;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			status_set_q <= 1'b0;
			stflg        <= '0;
		end else begin
			status_set_q <= status_set;
			if (status_rise)
				stflg <= stflg + STFLG_W'(1);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (status_rise)
			status_req <= status_in;
	end

	///////////////////////////////////////////////////////////////////////
	// host writes and read-back

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			io_dout  <= '0;
			cfg      <= '0;
			status   <= '0;
			joystick <= '0;
		end else if (io_op.kind == W_END) begin
			io_dout <= '0;
		end else if (io_op.kind == W_DATA) begin
			if (io_op.idx == '0) begin
				// response byte: tag nibble above the counter
				if (io_op.cmd == IO_STATUS_REQ)
					io_dout <= HOST_W'({STREQ_TAG, stflg});
				else
					io_dout <= '0;
			end else begin
				io_dout <= '0;
				case (io_op.cmd)
					IO_CFG:
						cfg <= io_op.data;
					IO_JOY0, IO_JOY1, IO_JOY2, IO_JOY3: begin
						if (io_op.idx == IDX_W'(1))
							joystick[joy_sel(io_op.cmd)][0 +: HOST_W] <= io_op.data;
						else
							joystick[joy_sel(io_op.cmd)][HOST_W +: HOST_W] <= io_op.data;
					end
					IO_STATUS:
						if (word_hit)
							status[word_sel*HOST_W +: HOST_W] <= io_op.data;
					IO_STATUS_REQ:
						if (word_hit)
							io_dout <= status_req[word_sel*HOST_W +: HOST_W];
					default:
						io_dout <= '0;
				endcase
			end
		end
	end

	// joystick slot of a joystick command
	function automatic int joy_sel(input io_cmd_e cmd);
		case (cmd)
			IO_JOY1: joy_sel = 1;
			IO_JOY2: joy_sel = 2;
			IO_JOY3: joy_sel = 3;
			default: joy_sel = 0;
		endcase
	endfunction

endmodule

/* hps_cmd_decoder.sv */
/*
 * Stage 2. Latches the command word of each channel and sends typed
 * ops to the user-I/O registers and to the file loader.
 */

`timescale 1ns/1ps

module hps_cmd_decoder import hps_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst,
	input  host_word_t word,
	output io_op_t     io_op,
	output fio_op_t    fio_op
);

	io_cmd_e  io_cmd_q;
	fio_cmd_e fio_cmd_q;
	io_cmd_e  io_map;
	fio_cmd_e fio_map;
	logic     first;

	function automatic io_cmd_e map_io(input logic [HOST_W-1:0] raw);
		case (raw)
			IO_CFG, IO_JOY0, IO_JOY1, IO_JOY2, IO_JOY3,
			IO_STATUS, IO_STATUS_REQ:
				map_io = io_cmd_e'(raw);
			default:
				map_io = IO_OTHER;
		endcase
	endfunction

	function automatic fio_cmd_e map_fio(input logic [HOST_W-1:0] raw);
		case (raw)
			FIO_FILE_TX, FIO_FILE_TX_DAT, FIO_FILE_INDEX, FIO_FILE_INFO:
				map_fio = fio_cmd_e'(raw);
			default:
				map_fio = FIO_OTHER;
		endcase
	endfunction

	assign io_map  = map_io(word.data);
	assign fio_map = map_fio(word.data);

	// command word of a frame
	assign first = (word.kind == W_DATA) && (word.idx == '0);

	always_ff @(posedge clk_sys) begin
		io_op.cmd   <= first ? io_map : io_cmd_q;
		io_op.idx   <= word.idx;
		io_op.data  <= word.data;
		fio_op.cmd  <= first ? fio_map : fio_cmd_q;
		fio_op.idx  <= word.idx;
		fio_op.data <= word.data;
		if (rst) begin
			io_cmd_q     <= IO_OTHER;
			fio_cmd_q    <= FIO_OTHER;
			io_op.kind   <= W_NONE;
			fio_op.valid <= 1'b0;
		end else begin
			io_op.kind   <= W_NONE;
			fio_op.valid <= 1'b0;
			if (word.kind != W_NONE) begin
				if (word.chan == CH_IO) begin
					io_op.kind <= word.kind;
					if (first)
						io_cmd_q <= io_map;
				end else begin
					// file side has no use for the end mark
					fio_op.valid <= (word.kind == W_DATA);
					if (first)
						fio_cmd_q <= fio_map;
				end
			end
		end
	end

	a_one_sink: assert property (@(posedge clk_sys) disable iff (rst)
		!((io_op.kind != W_NONE) && fio_op.valid))
		else $error("user-I/O and file-I/O ops in the same cycle");

endmodule

/* hps_word_framer.sv */
/*
 * Stage 1. Turns host strobes under io_enable or fp_enable into indexed
 * word records, plus one end record after each frame.
 */

`timescale 1ns/1ps

module hps_word_framer import hps_pkg::*; (
	input  logic              clk_sys,
	input  logic              rst,
	input  logic              io_strobe,
	input  logic              io_enable,
	input  logic              fp_enable,
	input  logic [HOST_W-1:0] io_din,
	output host_word_t        word
);

	logic [IDX_W-1:0] idx;
	logic             io_en_q;
	logic             fp_en_q;
	logic             io_fall;
	logic             fp_fall;
	logic             take;
	chan_e            chan_nxt;

	assign io_fall = io_en_q & ~io_enable;
	assign fp_fall = fp_en_q & ~fp_enable;
	assign take    = io_strobe & (io_enable | fp_enable);

	// a falling enable names its own channel
	always_comb begin
		if (io_fall)
			chan_nxt = CH_IO;
		else if (fp_fall)
			chan_nxt = CH_FIO;
		else
			chan_nxt = fp_enable ? CH_FIO : CH_IO;
	end

	always_ff @(posedge clk_sys) begin
		word.chan <= chan_nxt;
		word.idx  <= idx;
		word.data <= io_din;
		if (rst) begin
			word.kind <= W_NONE;
			idx       <= '0;
			io_en_q   <= 1'b0;
			fp_en_q   <= 1'b0;
		end else begin
			io_en_q <= io_enable;
			fp_en_q <= fp_enable;
			if (io_fall | fp_fall) begin
				word.kind <= W_END;
				idx       <= '0;
			end else if (take) begin
				word.kind <= W_DATA;
				// index sticks at 7 for long frames
				if (idx != '1)
					idx <= idx + IDX_W'(1);
			end else begin
				word.kind <= W_NONE;
			end
		end
	end

	a_one_frame: assert property (@(posedge clk_sys) disable iff (rst)
		!(io_enable && fp_enable))
		else $error("io_enable and fp_enable high together");

endmodule

/* hps_pkg.sv */
/*
 * Shared widths, command codes and stage records for the host link.
 * Every stage of the link imports this package.
 */

package hps_pkg;

	///////////////////////////////////////////////////////////////////////
	// widths

	localparam int HOST_W      = 16;
	localparam int IDX_W       = 3;
	localparam int JOY_N       = 4;
	localparam int JOY_W       = 32;
	localparam int STATUS_W    = 64;
	localparam int FILE_ADDR_W = 27;
	localparam int FILE_DATA_W = 8;
	localparam int STFLG_W     = 4;

	// status is moved as 16-bit host words
	localparam int STAT_WORDS  = STATUS_W / HOST_W;
	localparam int STAT_SEL_W  = $clog2(STAT_WORDS);

	// config word bit positions
	localparam int CFG_FSD_BIT = 4;
	localparam int CFG_DV_BIT  = 10;

	// marker nibble in front of the request counter on 0x29
	localparam logic [3:0] STREQ_TAG = 4'hA;

	///////////////////////////////////////////////////////////////////////
	// command codes

	typedef enum logic [HOST_W-1:0] {
		IO_CFG        = 16'h0001,
		IO_JOY0       = 16'h0002,
		IO_JOY1       = 16'h0003,
		IO_JOY2       = 16'h0010,
		IO_JOY3       = 16'h0011,
		IO_STATUS     = 16'h001E,
		IO_STATUS_REQ = 16'h0029,
		IO_OTHER      = 16'hFFFF
	} io_cmd_e;

	typedef enum logic [HOST_W-1:0] {
		FIO_FILE_TX     = 16'h0053,
		FIO_FILE_TX_DAT = 16'h0054,
		FIO_FILE_INDEX  = 16'h0055,
		FIO_FILE_INFO   = 16'h0056,
		FIO_OTHER       = 16'hFFFF
	} fio_cmd_e;

	///////////////////////////////////////////////////////////////////////
	// stage records

	typedef enum logic {
		CH_IO  = 1'b0,
		CH_FIO = 1'b1
	} chan_e;

	typedef enum logic [1:0] {
		W_NONE = 2'd0,
		W_DATA = 2'd1,
		W_END  = 2'd2
	} word_kind_e;

	// framer output, one per cycle
	typedef struct packed {
		word_kind_e        kind;
		chan_e             chan;
		logic [IDX_W-1:0]  idx;
		logic [HOST_W-1:0] data;
	} host_word_t;

	// user-I/O op, kind W_END marks the end of a frame
	typedef struct packed {
		word_kind_e        kind;
		io_cmd_e           cmd;
		logic [IDX_W-1:0]  idx;
		logic [HOST_W-1:0] data;
	} io_op_t;

	typedef struct packed {
		logic              valid;
		fio_cmd_e          cmd;
		logic [IDX_W-1:0]  idx;
		logic [HOST_W-1:0] data;
	} fio_op_t;

endpackage
